/* project.f */
hdl/icache_geom_pkg.sv
hdl/icache_ctrl_pkg.sv
hdl/icache_ram_if.sv
hdl/sram_sp.sv
hdl/icache_tag_ram.sv
hdl/icache_data_ram.sv
hdl/icache_way_select.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
testbench/icache_tb.sv

/* Makefile */
TOP := icache_tb

.PHONY: all sim lint clean

all: sim

obj_dir/V$(TOP): project.f $(wildcard hdl/*.sv testbench/*.sv)
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* testbench/icache_tb.sv */
//--------------------
// icache testbench
// fetch table, L2 model with random latency, checks
//--------------------
`default_nettype none

module icache_tb;
    import icache_geom_pkg::*;

    localparam int          rst_cycles   = 5;
    localparam int          num_tests    = 19;
    localparam int          max_cycles   = num_tests * (8 + 8) + rst_cycles;  // worst miss < 16
    localparam logic [31:0] word_pattern = 32'h5a3c_96e1;  // L2 data scramble

    typedef struct packed {
        addr_t addr;
        logic  miss;    // refill from L2 expected
    } test_t;

    // set 0x12 takes tags 1, 2 and 3, the rest are lone lines
    test_t tests [num_tests] = '{
        '{32'h0001_0000, 1'b1},    // cold miss
        '{32'h0001_0000, 1'b0},    // same word hits
        '{32'h0001_0004, 1'b0},    // other word of the line
        '{32'h0000_0890, 1'b1},    // tag 1 -> way 0
        '{32'h0000_1094, 1'b1},    // tag 2 -> way 1
        '{32'h0000_0890, 1'b0},
        '{32'h0000_1090, 1'b0},
        '{32'h0000_1890, 1'b1},    // tag 3 evicts way 0
        '{32'h0000_1094, 1'b0},    // tag 2 survives
        '{32'h0000_0894, 1'b1},    // tag 1 back, evicts way 1
        '{32'h0000_1890, 1'b0},
        '{32'h0000_1090, 1'b1},    // tag 2 evicts way 0
        '{32'h0000_0890, 1'b0},
        '{32'h0000_1894, 1'b1},    // tag 3 evicts way 1
        '{32'h0000_1090, 1'b0},
        '{32'h7fff_fffc, 1'b1},    // last set
        '{32'h7fff_fff8, 1'b0},
        '{32'hffff_f8f0, 1'b1},    // all-ones tag
        '{32'hffff_f8f4, 1'b0}
    };

    logic       clk = 1'b0;
    logic       arst_n;
    logic       fetch_req;
    addr_t      fetch_addr;
    logic       fetch_valid;
    word_t      fetch_data;
    logic       l2_req;
    line_addr_t l2_addr;
    logic       l2_valid;
    line_t      l2_data;

    logic [31:0] lfsr_state  = 32'd89398;
    int          cycle_count = 0;
    line_addr_t  req_line;      // line the L2 model is serving
    int          l2_delay;
    int          cycles;        // negedges since fetch_req
    int          misses;
    logic        done;
    tag_t        tag;
    index_t      idx;
    logic        model_miss;
    logic        victim;

    // reference replacement state, one entry per set
    tag_t model_tag   [2][num_sets];
    logic model_valid [2][num_sets];
    logic model_repl  [num_sets];

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    // 1 to 8 cycles, one lfsr step per bit
    function automatic int draw_delay();
        logic [2:0] bits;
        for (int b = 0; b < 3; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[b]    = lfsr_state[0];
        end
        return int'(bits) + 1;
    endfunction

    function automatic word_t expected_word(input addr_t a);
        return {a[31:2], 2'b00} ^ word_pattern;    // word byte address, scrambled
    endfunction

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    icache_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_valid(fetch_valid),
        .fetch_data (fetch_data),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .l2_valid   (l2_valid),
        .l2_data    (l2_data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: fetch table not finished after %0d cycles", cycle_count);
            stop_on_error();
        end
    end

    // L2 answers each request once, data from the line address
    always @(negedge clk) begin
        if (arst_n && l2_req) begin
            req_line = l2_addr;
            l2_delay = draw_delay();
            repeat (l2_delay) @(negedge clk);
            l2_valid = 1'b1;
            l2_data  = {expected_word({req_line, 3'b100}), expected_word({req_line, 3'b000})};
            @(negedge clk);
            l2_valid = 1'b0;
            l2_data  = '0;
        end
    end

    initial begin
        fetch_req  = 1'b0;
        fetch_addr = '0;
        l2_valid   = 1'b0;
        l2_data    = '0;
        arst_n     = 1'b0;
        for (int s = 0; s < num_sets; s++) begin
            model_valid[0][s] = 1'b0;
            model_valid[1][s] = 1'b0;
            model_tag[0][s]   = '0;
            model_tag[1][s]   = '0;
            model_repl[s]     = 1'b0;
        end
        repeat (rst_cycles) @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < num_tests; i++) begin
            tag = tests[i].addr[31 -: tag_bits];
            idx = tests[i].addr[offset_bits +: index_bits];
            model_miss = !((model_valid[0][idx] && model_tag[0][idx] == tag)
                        || (model_valid[1][idx] && model_tag[1][idx] == tag));
            if (model_miss != tests[i].miss) begin
                $display("table entry %0d does not match the replacement model", i);
                stop_on_error();
            end

            @(negedge clk);
            fetch_req  = 1'b1;
            fetch_addr = tests[i].addr;
            cycles     = 0;
            misses     = 0;
            done       = 1'b0;
            while (!done) begin
                @(negedge clk);
                fetch_req = 1'b0;
                cycles++;
                if (l2_req) begin
                    misses++;
                    check_value("l2_addr", 32'(l2_addr), 32'(tests[i].addr[31:3]));
                    check_value("l2_req cycle", cycles, 2);   // compare cycle of the lookup
                end
                done = fetch_valid;
            end
            check_value("fetch_data", fetch_data, expected_word(tests[i].addr));
            check_value("l2_req count", misses, 32'(tests[i].miss));
            if (!tests[i].miss) check_value("fetch_valid cycle", cycles, 2);

            // empty way first, then the set's replacement bit
            if (model_miss) begin
                if (!model_valid[0][idx])      victim = 1'b0;
                else if (!model_valid[1][idx]) victim = 1'b1;
                else                           victim = model_repl[idx];
                model_valid[victim][idx] = 1'b1;
                model_tag[victim][idx]   = tag;
                model_repl[idx]          = !victim;
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/icache_top.sv */
//--------------------
// icache top
// 2-way instruction cache, fetch and L2 ports
//--------------------
`default_nettype none

module icache_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fetch_req,
    input  icache_geom_pkg::addr_t      fetch_addr,
    output logic                        fetch_valid,
    output icache_geom_pkg::word_t      fetch_data,
    output logic                        l2_req,
    output icache_geom_pkg::line_addr_t l2_addr,
    input  logic                        l2_valid,
    input  icache_geom_pkg::line_t      l2_data
);
    import icache_geom_pkg::*;

    tag_t  lookup_tag;
    logic  word_sel;
    tag_t  tag0_rd;
    tag_t  tag1_rd;
    logic  valid0;
    logic  valid1;
    logic  repl_way;
    logic  complete;
    line_t line0_rd;
    line_t line1_rd;
    logic  hit;
    word_t hit_word;
    logic  victim_way;

    icache_ram_if ram ();   // shared store bus

    icache_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .hit        (hit),
        .hit_word   (hit_word),
        .victim_way (victim_way),
        .complete   (complete),
        .l2_valid   (l2_valid),
        .l2_data    (l2_data),
        .ram        (ram),
        .lookup_tag (lookup_tag),
        .word_sel   (word_sel),
        .fetch_valid(fetch_valid),
        .fetch_data (fetch_data),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr)
    );

    icache_tag_ram u_tag_ram (
        .clk     (clk),
        .arst_n  (arst_n),
        .ram     (ram),
        .tag0_rd (tag0_rd),
        .tag1_rd (tag1_rd),
        .valid0  (valid0),
        .valid1  (valid1),
        .repl_way(repl_way),
        .complete(complete)
    );

    icache_data_ram u_data_ram (
        .clk     (clk),
        .ram     (ram),
        .line0_rd(line0_rd),
        .line1_rd(line1_rd)
    );

    icache_way_select u_way_select (
        .lookup_tag(lookup_tag),
        .word_sel  (word_sel),
        .tag0_rd   (tag0_rd),
        .tag1_rd   (tag1_rd),
        .valid0    (valid0),
        .valid1    (valid1),
        .repl_way  (repl_way),
        .line0_rd  (line0_rd),
        .line1_rd  (line1_rd),
        .hit       (hit),
        .hit_word  (hit_word),
        .victim_way(victim_way)
    );

endmodule

`default_nettype wire

/* hdl/icache_ctrl.sv */
//--------------------
// icache controller
// lookup, L2 refill and retry FSM
//--------------------
`default_nettype none

module icache_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fetch_req,     // one cycle pulse
    input  icache_geom_pkg::addr_t      fetch_addr,
    input  logic                        hit,
    input  icache_geom_pkg::word_t      hit_word,
    input  logic                        victim_way,
    input  logic                        complete,
    input  logic                        l2_valid,
    input  icache_geom_pkg::line_t      l2_data,
    icache_ram_if.ctrl                  ram,
    output icache_geom_pkg::tag_t       lookup_tag,
    output logic                        word_sel,
    output logic                        fetch_valid,
    output icache_geom_pkg::word_t      fetch_data,
    output logic                        l2_req,
    output icache_geom_pkg::line_addr_t l2_addr
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    ctrl_state_t state;
    logic        cmp_en;        // store outputs valid this cycle
    logic        cmp;           // compare cycle of a lookup
    logic        accept;        // take a new fetch
    addr_t       addr_q;
    line_t       line_q;        // refill line held for the write
    logic        way0_we_q;
    logic        way1_we_q;

    assign cmp         = (state == lookup) && cmp_en;
    assign fetch_valid = cmp && hit;
    assign fetch_data  = hit_word;
    assign l2_req      = cmp && !hit;
    assign accept      = fetch_req && ((state == idle) || fetch_valid);

    // address fields
    assign lookup_tag = addr_q[offset_bits+index_bits +: tag_bits];
    assign word_sel   = addr_q[offset_bits-1];
    assign l2_addr    = addr_q[offset_bits +: tag_bits+index_bits];

    assign ram.index   = addr_q[offset_bits +: index_bits];
    assign ram.tag_wd  = lookup_tag;
    assign ram.line_wd = line_q;
    assign ram.way0_we = way0_we_q;
    assign ram.way1_we = way1_we_q;

    always_ff @(posedge clk) begin
        if (accept) addr_q <= fetch_addr;
        if ((state == refill_wait) && l2_valid) line_q <= l2_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= idle;
            cmp_en    <= 1'b0;
            way0_we_q <= ram_read;
            way1_we_q <= ram_read;
        end else begin
            way0_we_q <= ram_read;          // strobes last one cycle
            way1_we_q <= ram_read;
            case (state)
                idle: begin
                    if (accept) begin
                        state  <= lookup;
                        cmp_en <= 1'b0;
                    end
                end
                lookup: begin
                    if (!cmp_en) begin
                        cmp_en <= 1'b1;     // stores read at this edge
                    end else if (hit) begin
                        if (accept) cmp_en <= 1'b0;  // back to back fetch
                        else        state  <= idle;
                    end else begin
                        state <= refill_wait;
                    end
                end
                refill_wait: begin
                    if (l2_valid) begin
                        state     <= refill_write;
                        way0_we_q <= victim_way ? ram_read : ram_write;
                        way1_we_q <= victim_way ? ram_write : ram_read;
                    end
                end
                refill_write: begin
                    if (complete) state <= retry;
                end
                retry: begin
                    state  <= lookup;
                    cmp_en <= 1'b1;         // stores re-read at this edge
                end
                default: state <= idle;
            endcase
        end
    end

    // a retry lookup must hit the line just written
    a_req_on_miss: assert property (@(posedge clk) disable iff (!arst_n)
        l2_req |-> ($past(state) != retry));

endmodule

`default_nettype wire

/* hdl/icache_way_select.sv */
//--------------------
// icache way select
// tag compare, word mux, victim choice
//--------------------
`default_nettype none

module icache_way_select (
    input  icache_geom_pkg::tag_t  lookup_tag,
    input  logic                   word_sel,     // addr bit 2
    input  icache_geom_pkg::tag_t  tag0_rd,
    input  icache_geom_pkg::tag_t  tag1_rd,
    input  logic                   valid0,
    input  logic                   valid1,
    input  logic                   repl_way,
    input  icache_geom_pkg::line_t line0_rd,
    input  icache_geom_pkg::line_t line1_rd,
    output logic                   hit,
    output icache_geom_pkg::word_t hit_word,
    output logic                   victim_way
);
    import icache_geom_pkg::*;

    logic  hit0;
    logic  hit1;
    line_t sel_line;    // line of the hitting way

    assign hit0 = valid0 && (tag0_rd == lookup_tag);
    assign hit1 = valid1 && (tag1_rd == lookup_tag);
    assign hit  = hit0 || hit1;

    assign sel_line = hit1 ? line1_rd : line0_rd;
    assign hit_word = word_sel ? sel_line[line_bits-1:line_bits/2]
                               : sel_line[line_bits/2-1:0];

    // fill empty ways first, way 0 before way 1
    always_comb begin
        if (!valid0) begin
            victim_way = 1'b0;
        end else if (!valid1) begin
            victim_way = 1'b1;
        end else begin
            victim_way = repl_way;      // alternating per set
        end
    end

    // refill only on miss, so a tag never sits in both ways
    always_comb begin
        a_single_hit: assert (!(hit0 && hit1))
            else $error("tag present in both ways");
    end

endmodule

`default_nettype wire

/* hdl/icache_data_ram.sv */
//--------------------
// icache data store
// line data per way, same read timing as tags
//--------------------
`default_nettype none

module icache_data_ram (
    input  logic                   clk,
    icache_ram_if.data             ram,
    output icache_geom_pkg::line_t line0_rd,
    output icache_geom_pkg::line_t line1_rd
);
    import icache_geom_pkg::*;

    // way 0 lines
    sram_sp #(.width(line_bits), .depth(num_sets)) data_way0 (
        .clk    (clk),
        .address(ram.index),
        .data   (ram.line_wd),
        .wren   (ram.way0_we),
        .q      (line0_rd)
    );

    // way 1 lines
    sram_sp #(.width(line_bits), .depth(num_sets)) data_way1 (
        .clk    (clk),
        .address(ram.index),
        .data   (ram.line_wd),
        .wren   (ram.way1_we),
        .q      (line1_rd)
    );

endmodule

`default_nettype wire

/* hdl/icache_tag_ram.sv */
//--------------------
// icache tag store
// tag ways, valid bits, replacement bit, refill done
//--------------------
`default_nettype none

module icache_tag_ram (
    input  logic                  clk,
    input  logic                  arst_n,
    icache_ram_if.tag             ram,
    output icache_geom_pkg::tag_t tag0_rd,
    output icache_geom_pkg::tag_t tag1_rd,
    output logic                  valid0,
    output logic                  valid1,
    output logic                  repl_way,
    output logic                  complete      // one cycle after a refill write
);
    import icache_geom_pkg::*;
    import icache_ctrl_pkg::*;

    logic                repl_we;       // replacement field strobe
    logic                repl_wd;       // next way to replace
    logic [num_sets-1:0] valid0_arr;
    logic [num_sets-1:0] valid1_arr;

    // writing one way points replacement at the other
    always_comb begin
        repl_we = ram_read;
        repl_wd = 1'b0;
        if (ram.way0_we == ram_write) begin
            repl_we = ram_write;
            repl_wd = 1'b1;
        end else if (ram.way1_we == ram_write) begin
            repl_we = ram_write;
            repl_wd = 1'b0;
        end
    end

    // valid flops, cleared by reset only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid0_arr <= '0;
            valid1_arr <= '0;
            valid0     <= 1'b0;
            valid1     <= 1'b0;
            complete   <= 1'b0;
        end else begin
            if (ram.way0_we == ram_write) valid0_arr[ram.index] <= 1'b1;
            if (ram.way1_we == ram_write) valid1_arr[ram.index] <= 1'b1;
            // same read timing as the srams
            valid0   <= (ram.way0_we == ram_write) || valid0_arr[ram.index];
            valid1   <= (ram.way1_we == ram_write) || valid1_arr[ram.index];
            complete <= (ram.way0_we == ram_write) || (ram.way1_we == ram_write);
        end
    end

    sram_sp #(.width(tag_bits), .depth(num_sets)) tag_way0 (
        .clk    (clk),
        .address(ram.index),
        .data   (ram.tag_wd),
        .wren   (ram.way0_we),
        .q      (tag0_rd)
    );

    sram_sp #(.width(tag_bits), .depth(num_sets)) tag_way1 (
        .clk    (clk),
        .address(ram.index),
        .data   (ram.tag_wd),
        .wren   (ram.way1_we),
        .q      (tag1_rd)
    );

    sram_sp #(.width(1), .depth(num_sets)) repl_field (
        .clk    (clk),
        .address(ram.index),
        .data   (repl_wd),
        .wren   (repl_we),
        .q      (repl_way)
    );

    // controller must pick exactly one victim
    a_one_way_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(ram.way0_we && ram.way1_we));

endmodule

`default_nettype wire

/* hdl/sram_sp.sv */
//--------------------
// single port sram
// registered read, write-through to q
//--------------------
`default_nettype none

module sram_sp #(
    parameter int width = 32,   // word width
    parameter int depth = 256   // entries
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] address,
    input  logic [width-1:0]         data,
    input  logic                     wren,
    output logic [width-1:0]         q
);

    logic [width-1:0] mem [depth];

    // one edge from address to q
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
            q            <= data;        // new data visible right away
        end else begin
            q <= mem[address];
        end
    end

endmodule

`default_nettype wire

/* hdl/icache_ram_if.sv */
//--------------------
// icache store bus
// shared index, way strobes and write data
//--------------------
`default_nettype none

interface icache_ram_if ();
    import icache_geom_pkg::*;

    index_t index;      // set address, same for both stores
    logic   way0_we;    // refill strobe way 0
    logic   way1_we;    // refill strobe way 1
    tag_t   tag_wd;     // tag of refilled line
    line_t  line_wd;    // refill data from L2

    // controller owns the bus
    modport ctrl (
        output index, way0_we, way1_we, tag_wd, line_wd
    );

    modport tag (
        input index, way0_we, way1_we, tag_wd
    );

    modport data (
        input index, way0_we, way1_we, line_wd
    );

endinterface

`default_nettype wire

/* hdl/icache_ctrl_pkg.sv */
//--------------------
// icache controller defs
// FSM states and store write levels
//--------------------
`default_nettype none

package icache_ctrl_pkg;

    // lookup covers the ram read cycle and the compare cycle
    typedef enum logic [2:0] {
        idle,           // waiting for fetch_req
        lookup,         // read, then tag compare
        refill_wait,    // l2_req sent, waiting l2_valid
        refill_write,   // way strobe high, then wait complete
        retry           // re-read after refill
    } ctrl_state_t;

    // write strobe is active high
    localparam logic ram_read  = 1'b0;
    localparam logic ram_write = 1'b1;

endpackage

`default_nettype wire

/* hdl/icache_geom_pkg.sv */
//--------------------
// icache geometry
// set count, field widths and address/line types
//--------------------
`default_nettype none

package icache_geom_pkg;

    localparam int num_sets    = 256;  // two ways per set
    localparam int tag_bits    = 21;   // addr[31:11]
    localparam int index_bits  = 8;    // addr[10:3]
    localparam int offset_bits = 3;    // byte in line, only bit 2 used
    localparam int line_bits   = 64;   // two instruction words

    // full fetch address
    typedef logic [tag_bits+index_bits+offset_bits-1:0] addr_t;

    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [index_bits-1:0] index_t;

    // one instruction
    typedef logic [line_bits/2-1:0] word_t;

    // low word sits at offset 0
    typedef logic [line_bits-1:0] line_t;

    // tag and index, sent to L2
    typedef logic [tag_bits+index_bits-1:0] line_addr_t;

endpackage

`default_nettype wire
